// ==== Bender.yml ====
package:
  name: uart_periph

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_bus_pkg.sv
      - verilog/uart_line_pkg.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/uart_regs.sv
      - verilog/uart_top.sv
  - target: test
    include_dirs:
      - verilog
      - verif
    files:
      - verif/tb_uart_top.sv

// ==== files.f ====
+incdir+verilog
+incdir+verif
verilog/uart_bus_pkg.sv
verilog/uart_line_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
verif/tb_uart_top.sv

// ==== verif/tb_uart_tasks.svh ====
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// ============================================================
// Bus access
// ============================================================

task automatic drive_idle();
  bus = '0;  // Select and write low, so a seen receive byte can clear.
endtask

// Drives a read from the current falling edge and samples mid low phase.
task automatic sample_read(input logic addr, output uart_rdata_u word);
  bus = uart_bus_req_t'{select: 1'b1, write: 1'b0, address: addr, be: 4'hf, wdata: '0};
  #2;
  word.raw = rdata;
endtask

task automatic read_reg(input logic addr, output uart_rdata_u word);
  @(negedge clk);
  sample_read(addr, word);
  @(negedge clk);
  drive_idle();
endtask

task automatic write_reg(input logic addr, input logic [3:0] be, input logic [31:0] data);
  @(negedge clk);
  bus = uart_bus_req_t'{select: 1'b1, write: 1'b1, address: addr, be: be, wdata: data};
  @(negedge clk);
  drive_idle();
endtask

// Polls address 0 until rx_valid (want_rx high) or tx_ready reads high.
task automatic wait_status(input logic want_rx, output uart_rdata_u word);
  int   polls;
  logic hit;
  polls = 0;
  hit   = 1'b0;
  while (!hit && polls < POLL_LIMIT) begin
    read_reg(1'b0, word);
    hit = want_rx ? word.status.rx_valid : word.status.tx_ready;
    polls++;
  end
  if (!hit) begin
    $display("Timeout: %s never read high within %0d status reads.",
             want_rx ? "rx_valid" : "tx_ready", POLL_LIMIT);
    timeouts++;
  end
endtask

// ============================================================
// Serial line
// ============================================================

// Start bit, eight data bits LSB first, then the given stop bit.
task automatic drive_frame(input uart_byte_t data, input logic stop_bit);
  logic [9:0] bits;
  int         i;
  bits = {stop_bit, data, 1'b0};
  for (i = 0; i < 10; i++) begin
    @(negedge clk);
    rx = bits[i];
    repeat (CPB - 1) @(negedge clk);
  end
  @(negedge clk);
  rx = 1'b1;
endtask

// Samples a tx frame at bit centers; reads tx_ready during the start bit
// and, if asked, writes extra_byte in the middle of the frame.
task automatic capture_frame(input logic extra_write, input uart_byte_t extra_byte,
                             output logic [9:0] bits, output logic ready_mid);
  uart_rdata_u word;
  int          cycles;
  int          i;
  cycles    = 0;
  bits      = '1;
  ready_mid = 1'b1;
  while (tx !== 1'b0 && cycles < FRAME_TIMEOUT) begin
    @(negedge clk);
    cycles++;
  end
  if (tx !== 1'b0) begin
    $display("Timeout: no start bit on tx within %0d cycles.", FRAME_TIMEOUT);
    timeouts++;
    return;
  end
  repeat (CPB / 2) @(negedge clk);  // Center of the start bit.
  for (i = 0; i < 10; i++) begin
    bits[i] = tx;
    if (i == 0) begin
      sample_read(1'b0, word);
      ready_mid = word.status.tx_ready;
    end else if (i == 4 && extra_write) begin
      bus = uart_bus_req_t'{select: 1'b1, write: 1'b1, address: 1'b0, be: 4'hf,
                            wdata: {24'h0, extra_byte}};
    end
    if (i < 9) begin
      @(negedge clk);
      drive_idle();
      repeat (CPB - 1) @(negedge clk);
    end
  end
endtask

task automatic expect_line_quiet(input int n_cycles, output logic quiet);
  quiet = 1'b1;
  repeat (n_cycles) begin
    @(negedge clk);
    if (tx !== 1'b1) quiet = 1'b0;  // Any low level means a frame started.
  end
endtask

`endif

// ==== verif/tb_uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module tb_uart_top;

  import uart_bus_pkg::*;
  import uart_line_pkg::*;

  localparam int CPB           = 16;        // Clocks per bit in the DUT.
  localparam int FRAME_TIMEOUT = 20 * CPB;  // Cycles allowed before a start bit.
  localparam int POLL_LIMIT    = 4 * CPB;   // Status reads allowed per poll.

  logic          clk;
  logic          rst_n;
  uart_bus_req_t bus;
  logic [31:0]   rdata;
  logic          rx;
  logic          tx;
  int            errors;
  int            timeouts;
  integer        seed;
  uart_rdata_u   word;
  logic [9:0]    bits;
  logic          ready_mid;
  logic          quiet;
  uart_byte_t    data;

  uart_top #(.clks_per_bit(CPB)) dut (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus),
    .rdata (rdata),
    .rx    (rx),
    .tx    (tx)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        errors++;
      end
  endtask

  `include "tb_uart_tasks.svh"

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    bus      = '0;
    rx       = 1'b1;  // Serial line idles high.
    errors   = 0;
    timeouts = 0;
    seed     = 32'ha651_0ca1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_value("reset tx", 1, tx);
    read_reg(1'b0, word);
    check_value("reset tx_ready", 1, word.status.tx_ready);
    check_value("reset tx_pending", 0, word.status.tx_pending);
    check_value("reset rx_valid", 0, word.status.rx_valid);
    check_value("reset reserved", 0, {word.status.rsvd_hi, word.status.rsvd_lo});
    read_reg(1'b1, word);
    check_value("id word", `UART_ID_WORD, word.raw);

    repeat (4) begin
      data = uart_byte_t'($random(seed));
      write_reg(1'b0, 4'h1, {24'h0, data});
      capture_frame(1'b0, 8'h00, bits, ready_mid);
      check_value("tx start bit", 0, bits[0]);
      check_value("tx data", data, bits[8:1]);
      check_value("tx stop bit", 1, bits[9]);
      check_value("tx_ready in frame", 0, ready_mid);
      wait_status(1'b0, word);
    end

    // The write made mid frame must not produce a second frame.
    write_reg(1'b0, 4'h1, 32'h5a);
    capture_frame(1'b1, 8'ha5, bits, ready_mid);
    check_value("busy write frame", 32'h5a, bits[8:1]);
    expect_line_quiet(13 * CPB, quiet);
    check_value("busy write dropped", 1, quiet);
    write_reg(1'b0, 4'he, 32'h3c);
    expect_line_quiet(12 * CPB, quiet);
    check_value("be0 low dropped", 1, quiet);
    write_reg(1'b1, 4'hf, 32'hc3);
    expect_line_quiet(12 * CPB, quiet);
    check_value("addr 1 write dropped", 1, quiet);

    repeat (4) begin
      data = uart_byte_t'($random(seed));
      drive_frame(data, 1'b1);
      wait_status(1'b1, word);
      check_value("rx byte", data, word.status.rx_byte);
      read_reg(1'b0, word);
      check_value("rx valid cleared", 0, word.status.rx_valid);
    end

    drive_frame(8'h96, 1'b0);
    repeat (CPB) begin  // Two cycles per read, so two bit times in all.
      read_reg(1'b0, word);
      check_value("framing error rx_valid", 0, word.status.rx_valid);
    end
    data = uart_byte_t'($random(seed));
    drive_frame(data, 1'b1);
    wait_status(1'b1, word);
    check_value("rx after framing error", data, word.status.rx_byte);

    $display("Checks done with %0d errors and %0d timeouts.", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/uart_bus_pkg.sv ====
`default_nettype none

package uart_bus_pkg;

  // ============================================================
  // Bus request
  // ============================================================

  // One bus cycle, as driven by the processor.
  typedef struct packed {
    logic        select;   // Peripheral is addressed this cycle.
    logic        write;    // High for a write, low for a read.
    logic        address;  // Register index, 0 or 1.
    logic [3:0]  be;       // Byte enables, only be[0] matters here.
    logic [31:0] wdata;    // Write data, byte 0 is the transmit byte.
  } uart_bus_req_t;

  // ============================================================
  // Read data
  // ============================================================

  // Layout of the address 0 read word.
  typedef struct packed {
    logic [15:0] rsvd_hi;     // Reads as zero.
    logic        rx_valid;    // A received byte is waiting or was just read.
    logic        tx_pending;  // A written byte has not yet been handed to the transmitter.
    logic        tx_ready;    // Transmitter is idle.
    logic [4:0]  rsvd_lo;     // Reads as zero.
    logic [7:0]  rx_byte;     // Last received byte.
  } uart_status_t;

  // The same 32-bit word seen raw or as status fields.
  typedef union packed {
    logic [31:0]  raw;
    uart_status_t status;
  } uart_rdata_u;

endpackage

`default_nettype wire

// ==== verilog/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// ============================================================
// Clock and line rate
// ============================================================

`define UART_CLK_FREQ 125000000  // System clock in Hz.
`define UART_BAUD 115200         // Serial line rate in bits per second.

// Whole clock cycles per serial bit, rounded down.
`define UART_CLKS_PER_BIT (`UART_CLK_FREQ / `UART_BAUD)

// ============================================================
// Identification
// ============================================================

// Returned by a read of address 1.
`define UART_ID_WORD 32'hbeef0023

`endif

// ==== verilog/uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

  // ============================================================
  // Serial line data
  // ============================================================

  typedef logic [7:0] uart_byte_t;  // One data byte on the line.

  // Request from the register block to the transmitter.
  typedef struct packed {
    logic       start;  // One-cycle pulse, only while the transmitter is ready.
    uart_byte_t data;   // Byte to send, held from the pulse onward.
  } uart_tx_cmd_t;

  // Report from the receiver to the register block.
  typedef struct packed {
    logic       valid;  // One-cycle pulse per good frame.
    uart_byte_t data;   // Received byte, valid with the pulse.
  } uart_rx_event_t;

endpackage

`default_nettype wire

// ==== verilog/uart_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_regs (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire uart_bus_pkg::uart_bus_req_t   bus,
  output logic [31:0]                        rdata,
  output uart_line_pkg::uart_tx_cmd_t        tx_cmd,
  input  wire logic                          tx_ready,
  input  wire uart_line_pkg::uart_rx_event_t rx_event
);

  import uart_bus_pkg::*;
  import uart_line_pkg::*;

  // Bit 0 doubles as the rx_valid flag.
  typedef enum logic [1:0] {
    RX_EMPTY = 2'b00,
    RX_NEW   = 2'b01,
    RX_SEEN  = 2'b11
  } rx_state_e;

  uart_byte_t  tx_byte;     // Byte waiting for or being sent by the transmitter.
  logic        tx_pending;  // Write accepted, start not yet issued.
  logic        tx_start;    // Registered start pulse.
  logic        tx_launch;
  uart_byte_t  rx_byte;
  rx_state_e   rx_state;
  logic        bus_rd;
  logic        bus_idle;
  logic        wr_accept;
  logic        rd_status;
  uart_rdata_u rd_word;

  // ============================================================
  // Bus decode
  // ============================================================

  assign bus_rd    = bus.select & ~bus.write;
  assign bus_idle  = ~bus.select & ~bus.write;
  assign rd_status = bus_rd & ~bus.address;
  // Writes while the transmitter is busy are simply lost.
  assign wr_accept = bus.select & bus.write & ~bus.address & bus.be[0] & tx_ready;

  // ============================================================
  // Transmit side
  // ============================================================

  // A waiting byte goes out as soon as the transmitter is idle.
  assign tx_launch = tx_pending & tx_ready;

  always_ff @(posedge clk) begin
    if (wr_accept) tx_byte <= bus.wdata[7:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_pending <= 1'b0;
      tx_start   <= 1'b0;
    end else begin
      tx_start <= tx_launch;
      if (tx_launch) begin
        tx_pending <= 1'b0;  // Launch wins over a write in the same cycle.
      end else if (wr_accept) begin
        tx_pending <= 1'b1;
      end
    end
  end

  assign tx_cmd = uart_tx_cmd_t'{start: tx_start, data: tx_byte};

  // ============================================================
  // Receive side
  // ============================================================

  always_ff @(posedge clk) begin
    if (rx_event.valid) rx_byte <= rx_event.data;
  end

  // A new byte always overwrites, read or not.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_state <= RX_EMPTY;
    end else if (rx_event.valid) begin
      rx_state <= RX_NEW;
    end else if (rd_status && rx_state == RX_NEW) begin
      rx_state <= RX_SEEN;
    end else if (bus_idle && rx_state == RX_SEEN) begin
      rx_state <= RX_EMPTY;  // Cleared once software lets go of the bus.
    end
  end

  // ============================================================
  // Read multiplexer
  // ============================================================

  always_comb begin
    rd_word.raw = '0;
    if (bus_rd) begin
      if (bus.address) begin
        rd_word.raw = `UART_ID_WORD;
      end else begin
        rd_word.status.rx_valid   = rx_state[0];
        rd_word.status.tx_pending = tx_pending;
        rd_word.status.tx_ready   = tx_ready;
        rd_word.status.rx_byte    = rx_byte;
      end
    end
  end

  assign rdata = rd_word.raw;

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_rx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   serial_in,
  output uart_line_pkg::uart_rx_event_t rx_event
);

  import uart_line_pkg::*;

  localparam int CNT_W = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(clks_per_bit - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'((clks_per_bit / 2) - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_e;

  rx_state_e        state;
  logic [1:0]       sync;      // Two-flop synchronizer, oldest in bit 1.
  logic             line;      // Synchronized serial input.
  logic             line_d;    // Line one cycle earlier, for edge detection.
  logic [CNT_W-1:0] baud_cnt;
  logic [2:0]       bit_cnt;   // Data bit index.
  uart_byte_t       data_sr;   // Assembled byte, LSB arrives first.
  logic             valid_q;

  assign line = sync[1];

  // ============================================================
  // Input synchronizer
  // ============================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync   <= 2'b11;  // Treat the line as idle out of reset.
      line_d <= 1'b1;
    end else begin
      sync   <= {sync[0], serial_in};
      line_d <= line;
    end
  end

  // ============================================================
  // Frame FSM
  // ============================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          baud_cnt <= '0;
          if (line_d && !line) state <= ST_START;  // Falling edge opens a frame.
        end
        ST_START: begin
          if (baud_cnt == HALF_END) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // A line back high at mid start bit was only a glitch.
            state    <= line ? ST_IDLE : ST_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        ST_DATA: begin
          if (baud_cnt == BIT_END) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= ST_STOP;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        ST_STOP: begin
          if (baud_cnt == BIT_END) begin
            baud_cnt <= '0;
            valid_q  <= line;  // A low stop bit drops the frame.
            state    <= ST_IDLE;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Sample each data bit at its center.
  always_ff @(posedge clk) begin
    if (state == ST_DATA && baud_cnt == BIT_END) data_sr <= {line, data_sr[7:1]};
  end

  assign rx_event = uart_rx_event_t'{valid: valid_q, data: data_sr};

endmodule

`default_nettype wire

// ==== verilog/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_top #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire uart_bus_pkg::uart_bus_req_t bus,
  output logic [31:0]                      rdata,
  input  wire logic                        rx,
  output logic                             tx
);

  import uart_line_pkg::*;

  uart_tx_cmd_t   tx_cmd;
  logic           tx_ready;
  uart_rx_event_t rx_event;

  // ============================================================
  // Register block
  // ============================================================

  uart_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus      (bus),
    .rdata    (rdata),
    .tx_cmd   (tx_cmd),
    .tx_ready (tx_ready),
    .rx_event (rx_event)
  );

  // ============================================================
  // Serial line
  // ============================================================

  uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (tx_cmd),
    .ready      (tx_ready),
    .serial_out (tx)
  );

  uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .serial_in (rx),
    .rx_event  (rx_event)
  );

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_tx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire uart_line_pkg::uart_tx_cmd_t cmd,
  output logic                             ready,
  output logic                             serial_out
);

  localparam int CNT_W = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(clks_per_bit - 1);
  localparam logic [3:0] LAST_BIT = 4'd9;  // Index of the stop bit.

  logic             busy;      // A frame is on the line.
  logic [CNT_W-1:0] baud_cnt;  // Clock cycles into the current bit.
  logic [3:0]       bit_cnt;   // 0 is the start bit, 9 is the stop bit.
  logic [8:0]       shift;     // Data bits still to go, stop bit on top.
  logic             bit_done;

  assign ready    = ~busy;
  assign bit_done = (baud_cnt == BIT_END);

  // ============================================================
  // Frame sequencing
  // ============================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
      serial_out <= 1'b1;  // Line idles high.
    end else if (!busy) begin
      if (cmd.start) begin
        busy       <= 1'b1;
        baud_cnt   <= '0;
        bit_cnt    <= '0;
        serial_out <= 1'b0;  // Start bit goes out right away.
      end
    end else if (bit_done) begin
      baud_cnt <= '0;
      if (bit_cnt == LAST_BIT) begin
        busy <= 1'b0;  // Stop bit is complete.
      end else begin
        bit_cnt    <= bit_cnt + 4'd1;
        serial_out <= shift[0];
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // ============================================================
  // Shift register
  // ============================================================

  // Loaded with the byte and a trailing stop bit, drained LSB first.
  always_ff @(posedge clk) begin
    if (!busy && cmd.start) begin
      shift <= {1'b1, cmd.data};
    end else if (busy && bit_done && bit_cnt != LAST_BIT) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

`default_nettype wire
